/* all.f */
+incdir+logic
logic/drbg_upd_pkg.sv
logic/drbg_upd_req_decode.sv
logic/drbg_upd_blk_issue.sv
logic/drbg_upd_outblk.sv
logic/drbg_upd_top.sv
dv/drbg_upd_chk.sv
dv/drbg_upd_tb.sv

/* dv/drbg_upd_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module drbg_upd_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic enable_i,
  input logic upd_req_i,
  input logic busy_i,
  input logic blk_req_i,
  input logic blk_ack_i,
  input logic upd_ack_i
);

  logic [3:0] acc_pipe;
  logic [1:0] ack_cnt;
  logic       accept;
  logic       exp_issue;
  logic       third_ack;
  int         err_cnt;

  assign accept    = enable_i && upd_req_i && !busy_i;
  // requests due 2, 3 and 4 cycles after the accept
  assign exp_issue = enable_i && (acc_pipe[1] || acc_pipe[2] || acc_pipe[3]);
  assign third_ack = enable_i && busy_i && blk_ack_i && (ack_cnt == 2'd2);

  // --------------------
  // reference history
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_pipe <= '0;
      ack_cnt  <= '0;
    end else if (!enable_i) begin
      acc_pipe <= '0;
      ack_cnt  <= '0;
    end else begin
      acc_pipe <= {acc_pipe[2:0], accept};
      if (accept) begin
        ack_cnt <= '0;
      end else if (busy_i && blk_ack_i && ack_cnt != 2'd3) begin
        ack_cnt <= ack_cnt + 2'd1;
      end
    end
  end

  // --------------------
  // properties
  // --------------------
  issue_timing_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    blk_req_i == exp_issue)
    else begin
      $error("blk_req_o not in step with the accepted request");
      err_cnt++;
    end

  ack_follows_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(third_ack) && enable_i) |-> upd_ack_i)
    else begin
      $error("upd_ack_o missing one cycle after the third blk_ack_i");
      err_cnt++;
    end

  ack_source_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_ack_i |-> $past(third_ack))
    else begin
      $error("upd_ack_o without a third blk_ack_i the cycle before");
      err_cnt++;
    end

  idle_quiet_a: assert property (@(posedge clk_i)
    (!rst_ni || !enable_i) |-> (!busy_i && !blk_req_i && !upd_ack_i))
    else begin
      $error("outputs active in reset or while disabled");
      err_cnt++;
    end

endmodule

`default_nettype wire

/* dv/drbg_upd_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "drbg_upd_cfg.svh"

module drbg_upd_tb;

  localparam int blk_len    = `DRBG_BLK_LEN;
  localparam int ctr_len    = `DRBG_CTR_LEN;
  localparam int seed_len   = `DRBG_SEED_LEN;
  localparam int clk_period = 20;
  localparam int num_rand   = 12;
  localparam int num_reqs   = num_rand + 4;
  localparam int timeout_ns = (num_reqs * 40 + 50) * clk_period;

  logic clk_i;
  logic rst_ni;
  logic enable_i;
  logic upd_req_i;
  logic busy_o;
  logic upd_ack_o;
  logic blk_req_o;
  logic blk_ack_i;
  drbg_upd_pkg::upd_req_t upd_req_data_i;
  drbg_upd_pkg::upd_rsp_t upd_rsp_o;
  drbg_upd_pkg::blk_req_t blk_req_data_o;
  drbg_upd_pkg::blk_rsp_t blk_ack_data_i;

  // scoreboard state
  drbg_upd_pkg::upd_req_t cur_req;
  drbg_upd_pkg::upd_rsp_t exp_rsp;
  logic                   rsp_pending;
  logic [blk_len-1:0]     exp_blk;
  int blk_idx;
  int done_cnt;
  int val_errs;
  int proto_errs;

  // cipher model queues
  logic [blk_len-1:0] ack_data_q[$];
  int ack_due_q[$];
  int cyc;
  int due;
  int last_due;

  drbg_upd_top dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .upd_req_i      (upd_req_i),
    .upd_req_data_i (upd_req_data_i),
    .busy_o         (busy_o),
    .upd_ack_o      (upd_ack_o),
    .upd_rsp_o      (upd_rsp_o),
    .blk_req_o      (blk_req_o),
    .blk_req_data_o (blk_req_data_o),
    .blk_ack_i      (blk_ack_i),
    .blk_ack_data_i (blk_ack_data_i)
  );

  bind drbg_upd_top drbg_upd_chk u_chk (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .enable_i  (enable_i),
    .upd_req_i (upd_req_i),
    .busy_i    (busy_o),
    .blk_req_i (blk_req_o),
    .blk_ack_i (blk_ack_i),
    .upd_ack_i (upd_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic logic [blk_len-1:0] cipher_out(input logic [2*blk_len-1:0] key,
                                                    input logic [blk_len-1:0] blk);
    return key[2*blk_len-1:blk_len] ^ key[blk_len-1:0] ^ blk;
  endfunction

  function automatic drbg_upd_pkg::upd_rsp_t expected_rsp(input drbg_upd_pkg::upd_req_t req);
    drbg_upd_pkg::upd_rsp_t rsp;
    logic [seed_len-1:0]    joined;
    logic [blk_len-1:0]     blk;
    for (int i = 0; i < `DRBG_NUM_BLKS; i++) begin
      blk = {req.v[blk_len-1:ctr_len], req.v[ctr_len-1:0] + ctr_len'(i + 1)};
      // first block on top
      joined[seed_len-1-i*blk_len -: blk_len] = cipher_out(req.key, blk);
    end
    joined      = joined ^ req.pdata;
    rsp.cmd     = req.cmd;
    rsp.inst_id = req.inst_id;
    rsp.key     = joined[seed_len-1:blk_len];
    rsp.v       = joined[blk_len-1:0];
    return rsp;
  endfunction

  function automatic logic [seed_len-1:0] rand_wide();
    logic [seed_len-1:0] w;
    for (int i = 0; i < seed_len / 32; i++) begin
      w[i*32 +: 32] = $urandom;
    end
    return w;
  endfunction

  function automatic drbg_upd_pkg::upd_req_t rand_req();
    drbg_upd_pkg::upd_req_t req;
    req.cmd     = `DRBG_CMD_W'($urandom);
    req.inst_id = `DRBG_ID_W'($urandom);
    req.key     = `DRBG_KEY_LEN'(rand_wide());
    req.v       = blk_len'(rand_wide());
    req.pdata   = rand_wide();
    return req;
  endfunction

  // --------------------
  // cipher model
  // --------------------
  always @(negedge clk_i) begin
    if (!enable_i) begin
      ack_data_q.delete();
      ack_due_q.delete();
    end else if (blk_req_o) begin
      due = cyc + int'($urandom_range(6, 1));
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      ack_data_q.push_back(cipher_out(blk_req_data_o.key, blk_req_data_o.blk));
      ack_due_q.push_back(due);
    end
  end

  initial begin
    blk_ack_i      = 1'b0;
    blk_ack_data_i = '0;
    forever begin
      @(posedge clk_i);
      cyc++;
      #2;
      if (ack_due_q.size() > 0 && ack_due_q[0] <= cyc) begin
        blk_ack_i          = 1'b1;
        blk_ack_data_i.blk = ack_data_q.pop_front();
        void'(ack_due_q.pop_front());
      end else begin
        blk_ack_i = 1'b0;
      end
    end
  end

  // --------------------
  // output checks
  // --------------------
  always @(negedge clk_i) begin
    if (blk_req_o) begin
      exp_blk = {cur_req.v[blk_len-1:ctr_len], cur_req.v[ctr_len-1:0] + ctr_len'(blk_idx + 1)};
      assert (blk_req_data_o.key == cur_req.key && blk_req_data_o.blk == exp_blk) else begin
        $display("Fail %0t: blk_req_data_o blk %h, expected %h", $time,
                 blk_req_data_o.blk, exp_blk);
        val_errs++;
      end
      blk_idx++;
    end
    if (upd_ack_o) begin
      assert (rsp_pending) else begin
        $display("upd_ack_o came at %0t with no update pending", $time);
        proto_errs++;
      end
      if (rsp_pending) begin
        assert (upd_rsp_o == exp_rsp) else begin
          $display("Fail %0t: upd_rsp_o %h, expected %h", $time, upd_rsp_o, exp_rsp);
          val_errs++;
        end
      end
      rsp_pending = 1'b0;
      done_cnt++;
    end
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic send_req(input drbg_upd_pkg::upd_req_t req, input logic want_rsp);
    @(posedge clk_i);
    #2;
    upd_req_i      = 1'b1;
    upd_req_data_i = req;
    cur_req        = req;
    blk_idx        = 0;
    exp_rsp        = expected_rsp(req);
    rsp_pending    = want_rsp;
  endtask

  task automatic run_update(input drbg_upd_pkg::upd_req_t req, input logic poke_busy);
    int start_cnt;
    start_cnt = done_cnt;
    send_req(req, 1'b1);
    @(posedge clk_i);
    #2;
    // strobe while busy must be dropped
    upd_req_i      = poke_busy;
    upd_req_data_i = rand_req();
    @(posedge clk_i);
    #2;
    upd_req_i = 1'b0;
    while (done_cnt == start_cnt) @(posedge clk_i);
  endtask

  task automatic abort_update(input drbg_upd_pkg::upd_req_t req);
    send_req(req, 1'b0);
    @(posedge clk_i);
    #2;
    upd_req_i = 1'b0;
    // two blocks out, then disable
    repeat (3) @(posedge clk_i);
    #2;
    enable_i = 1'b0;
    @(negedge clk_i);
    assert (!busy_o) else begin
      $display("Fail %0t: busy_o still high after enable_i fell", $time);
      val_errs++;
    end
    repeat (3) @(posedge clk_i);
    #2;
    enable_i = 1'b1;
  endtask

  initial begin
    drbg_upd_pkg::upd_req_t req;
    void'($urandom(32'hd5be));
    rst_ni         = 1'b0;
    enable_i       = 1'b0;
    upd_req_i      = 1'b0;
    upd_req_data_i = '0;
    rsp_pending    = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (3) @(posedge clk_i);
    #2;
    enable_i = 1'b1;
    for (int n = 0; n < num_rand; n++) begin
      run_update(rand_req(), 1'b0);
    end
    req = rand_req();
    req.v[ctr_len-1:0] = 32'hffff_fffe;
    run_update(req, 1'b0);
    run_update(rand_req(), 1'b1);
    abort_update(rand_req());
    run_update(rand_req(), 1'b0);
    repeat (8) @(posedge clk_i);
    $display("errors: %0d value, %0d protocol, %0d assertion", val_errs, proto_errs,
             dut.u_chk.err_cnt);
    if (val_errs == 0 && proto_errs == 0 && dut.u_chk.err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeout_ns);
    $display("timeout: run did not finish within %0d ns", timeout_ns);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/drbg_upd_blk_issue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "drbg_upd_cfg.svh"

module drbg_upd_blk_issue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    start_i,
  input  drbg_upd_pkg::upd_req_t  held_req_i,
  output logic                    blk_req_o,
  output drbg_upd_pkg::blk_req_t  blk_req_data_o
);

  localparam int unsigned blk_len  = `DRBG_BLK_LEN;
  localparam int unsigned ctr_len  = `DRBG_CTR_LEN;
  localparam int unsigned num_blks = `DRBG_NUM_BLKS;
  localparam int unsigned cnt_w    = $clog2(num_blks + 1);

  logic [ctr_len-1:0] ctr_q;
  logic [cnt_w-1:0]   left_q;
  logic               issuing;

  assign issuing = (left_q != '0);

  // --------------------
  // counter and issue count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q  <= '0;
      left_q <= '0;
    end else if (!enable_i) begin
      // abort, nothing more goes out
      ctr_q  <= '0;
      left_q <= '0;
    end else if (start_i) begin
      // first block already uses V+1
      ctr_q  <= held_req_i.v[ctr_len-1:0] + ctr_len'(1);
      left_q <= cnt_w'(num_blks);
    end else if (issuing) begin
      // plain 32-bit wrap, upper part of V never sees a carry
      ctr_q  <= ctr_q + ctr_len'(1);
      left_q <= left_q - cnt_w'(1);
    end
  end

  // --------------------
  // cipher request
  // --------------------
  assign blk_req_o          = issuing && enable_i;
  assign blk_req_data_o.key = held_req_i.key;
  assign blk_req_data_o.blk = {held_req_i.v[blk_len-1:ctr_len], ctr_q};

endmodule

`default_nettype wire

/* logic/drbg_upd_cfg.svh */
`ifndef DRBG_UPD_CFG_SVH
`define DRBG_UPD_CFG_SVH

// --------------------
// block and state lengths
// --------------------
`define DRBG_BLK_LEN 128
`define DRBG_KEY_LEN 256
`define DRBG_SEED_LEN 384

// low word of V that counts per block
`define DRBG_CTR_LEN 32

// cipher calls per update
`define DRBG_NUM_BLKS (`DRBG_SEED_LEN / `DRBG_BLK_LEN)

// --------------------
// command side fields
// --------------------
`define DRBG_CMD_W 3
`define DRBG_ID_W 4

`endif

/* logic/drbg_upd_outblk.sv */
`timescale 1ns/10ps
`default_nettype none

`include "drbg_upd_cfg.svh"

module drbg_upd_outblk (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    start_i,
  input  drbg_upd_pkg::upd_req_t  held_req_i,
  input  logic                    blk_ack_i,
  input  drbg_upd_pkg::blk_rsp_t  blk_ack_data_i,
  output logic                    done_o,
  output logic                    upd_ack_o,
  output drbg_upd_pkg::upd_rsp_t  upd_rsp_o
);

  localparam int unsigned blk_len  = `DRBG_BLK_LEN;
  localparam int unsigned key_len  = `DRBG_KEY_LEN;
  localparam int unsigned seed_len = `DRBG_SEED_LEN;
  localparam int unsigned num_blks = `DRBG_NUM_BLKS;
  localparam int unsigned cnt_w    = $clog2(num_blks);

  logic                   armed_q;
  logic [cnt_w-1:0]       cnt_q;
  logic                   ack_q;
  logic [seed_len-1:0]    cat_q;
  drbg_upd_pkg::upd_rsp_t rsp_q;
  logic                   take;
  logic                   last_ack;
  logic [seed_len-1:0]    cat_next;
  logic [seed_len-1:0]    upd_kv;

  // acks outside an armed update are ignored
  assign take     = armed_q && enable_i && blk_ack_i;
  assign last_ack = take && (cnt_q == cnt_w'(num_blks - 1));

  // earliest block ends up on top after all shifts
  assign cat_next = {cat_q[seed_len-blk_len-1:0], blk_ack_data_i.blk};
  assign upd_kv   = cat_next ^ held_req_i.pdata;

  // --------------------
  // ack tracking
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q <= 1'b0;
      cnt_q   <= '0;
      ack_q   <= 1'b0;
    end else if (!enable_i) begin
      armed_q <= 1'b0;
      cnt_q   <= '0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= last_ack;
      if (start_i) begin
        armed_q <= 1'b1;
        cnt_q   <= '0;
      end else if (last_ack) begin
        armed_q <= 1'b0;
        cnt_q   <= '0;
      end else if (take) begin
        cnt_q <= cnt_q + cnt_w'(1);
      end
    end
  end

  // --------------------
  // join and final xor
  // --------------------
  always_ff @(posedge clk_i) begin
    if (take) begin
      cat_q <= cat_next;
    end
    if (last_ack) begin
      rsp_q.cmd     <= held_req_i.cmd;
      rsp_q.inst_id <= held_req_i.inst_id;
      rsp_q.key     <= upd_kv[seed_len-1 -: key_len];
      rsp_q.v       <= upd_kv[blk_len-1:0];
    end
  end

  // done goes with the third ack so busy falls with upd_ack_o
  assign done_o    = last_ack;
  assign upd_ack_o = ack_q && enable_i;
  assign upd_rsp_o = rsp_q;

endmodule

`default_nettype wire

/* logic/drbg_upd_pkg.sv */
`default_nettype none

`include "drbg_upd_cfg.svh"

package drbg_upd_pkg;

  // update request as accepted from the host side
  typedef struct packed {
    logic [`DRBG_CMD_W-1:0]    cmd;
    logic [`DRBG_ID_W-1:0]     inst_id;
    logic [`DRBG_KEY_LEN-1:0]  key;
    logic [`DRBG_BLK_LEN-1:0]  v;
    logic [`DRBG_SEED_LEN-1:0] pdata;
  } upd_req_t;

  // updated state returned with the command echo
  typedef struct packed {
    logic [`DRBG_CMD_W-1:0]   cmd;
    logic [`DRBG_ID_W-1:0]    inst_id;
    logic [`DRBG_KEY_LEN-1:0] key;
    logic [`DRBG_BLK_LEN-1:0] v;
  } upd_rsp_t;

  // one block-encrypt call
  typedef struct packed {
    logic [`DRBG_KEY_LEN-1:0] key;
    logic [`DRBG_BLK_LEN-1:0] blk;
  } blk_req_t;

  typedef struct packed {
    logic [`DRBG_BLK_LEN-1:0] blk;
  } blk_rsp_t;

endpackage

`default_nettype wire

/* logic/drbg_upd_req_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module drbg_upd_req_decode (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    upd_req_i,
  input  drbg_upd_pkg::upd_req_t  upd_req_data_i,
  input  logic                    done_i,
  output logic                    busy_o,
  output logic                    start_o,
  output drbg_upd_pkg::upd_req_t  held_req_o
);

  logic                   accept;
  logic                   busy_q;
  logic                   start_q;
  drbg_upd_pkg::upd_req_t held_q;

  // one update at a time, strobes while busy are dropped
  assign accept = enable_i && upd_req_i && !busy_q;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      if (!enable_i) begin
        busy_q <= 1'b0;
      end else if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        // done comes with the last ack, so busy drops with the response
        busy_q <= 1'b0;
      end
    end
  end

  // --------------------
  // request hold
  // --------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      held_q <= upd_req_data_i;
    end
  end

  // disabled engine reads as idle right away
  assign busy_o     = busy_q && enable_i;
  assign start_o    = start_q;
  assign held_req_o = held_q;

endmodule

`default_nettype wire

/* logic/drbg_upd_top.sv */
`timescale 1ns/10ps
`default_nettype none

module drbg_upd_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,

  // update port
  input  logic                    upd_req_i,
  input  drbg_upd_pkg::upd_req_t  upd_req_data_i,
  output logic                    busy_o,
  output logic                    upd_ack_o,
  output drbg_upd_pkg::upd_rsp_t  upd_rsp_o,

  // block encrypt port
  output logic                    blk_req_o,
  output drbg_upd_pkg::blk_req_t  blk_req_data_o,
  input  logic                    blk_ack_i,
  input  drbg_upd_pkg::blk_rsp_t  blk_ack_data_i
);

  logic                   start;
  logic                   done;
  drbg_upd_pkg::upd_req_t held_req;

  drbg_upd_req_decode u_req_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .upd_req_i      (upd_req_i),
    .upd_req_data_i (upd_req_data_i),
    .done_i         (done),
    .busy_o         (busy_o),
    .start_o        (start),
    .held_req_o     (held_req)
  );

  drbg_upd_blk_issue u_blk_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .start_i        (start),
    .held_req_i     (held_req),
    .blk_req_o      (blk_req_o),
    .blk_req_data_o (blk_req_data_o)
  );

  drbg_upd_outblk u_outblk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .enable_i       (enable_i),
    .start_i        (start),
    .held_req_i     (held_req),
    .blk_ack_i      (blk_ack_i),
    .blk_ack_data_i (blk_ack_data_i),
    .done_o         (done),
    .upd_ack_o      (upd_ack_o),
    .upd_rsp_o      (upd_rsp_o)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the drbg update testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/10ps --top-module drbg_upd_tb \
  -f all.f -o drbg_upd_sim \
  && ./obj_dir/drbg_upd_sim 2>&1 | tee sim.log
grep -q "RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
